/* verilog/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Datapath word, shared by instructions and addresses
`define WORD_W 32

// Branch target buffer geometry
// Entry count must stay a power of two, index width is its log2
`define BTB_ENTRIES 16
`define BTB_IDX_W 4

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* verilog/isa_pkg.sv */
`include "fetch_params.svh"

package isa_pkg;

  // Instruction or byte address
  typedef logic [`WORD_W-1:0] word_t;

  // BTB set index, taken from PC[5:2]
  typedef logic [`BTB_IDX_W-1:0] btb_idx_t;

  // Everything above the index, PC[31:6]
  typedef logic [`WORD_W-`BTB_IDX_W-3:0] btb_tag_t;

  // Saturating branch counter
  // 0 and 1 lean not taken, 2 and 3 lean taken, so the MSB is the prediction
  typedef logic [1:0] counter_t;

endpackage

/* verilog/pc_unit.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module pc_unit import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  word_t imemload,
  input  logic  freeze,
  input  logic  redirect,
  input  word_t correct_pc,
  input  logic  predict_taken,
  input  word_t predicted_target,
  output logic  imemREN,
  output word_t imemaddr,
  output logic  fetched,
  output word_t fetched_pc,
  output word_t fetched_instr,
  output logic  fetched_pred
);

  word_t pc_q;
  word_t next_pc;
  logic  hit;
  logic  take;       // Word moves into the output register this edge
  logic  hold_valid;
  word_t hold_instr; // Hit parked while frozen

  assign hit  = ihit && imemREN;
  assign take = !redirect && !freeze && (hold_valid || hit);

  // Predicted target wins over sequential order
  assign next_pc = predict_taken ? predicted_target : pc_q + 32'd4;

  // No new request while a word is parked
  assign imemREN  = !hold_valid;
  assign imemaddr = pc_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q       <= `RESET_PC;
      hold_valid <= 1'b0;
      fetched    <= 1'b0;
    end else if (redirect) begin
      // Wrong path, drop everything in flight
      pc_q       <= correct_pc;
      hold_valid <= 1'b0;
      fetched    <= 1'b0;
    end else if (!freeze) begin
      fetched    <= take;
      hold_valid <= 1'b0; // Parked word leaves through take
      if (take) begin
        pc_q <= next_pc;
      end
    end else if (hit) begin
      hold_valid <= 1'b1; // PC stays put until release
    end
  end

  // Output register holds under freeze, along with fetched
  always_ff @(posedge CLK) begin
    if (take) begin
      fetched_pc    <= pc_q;
      fetched_instr <= hold_valid ? hold_instr : imemload;
      fetched_pred  <= predict_taken; // Lookup is still on this word's PC
    end
    if (freeze && hit) begin
      hold_instr <= imemload;
    end
  end

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module branch_predictor import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t lookup_pc,
  input  logic  update_btb,
  input  logic  branch_outcome,
  input  word_t update_pc,
  input  word_t branch_target,
  output logic  predict_taken,
  output word_t predicted_target
);

  localparam counter_t CNT_MIN  = 2'd0;
  localparam counter_t CNT_INIT = 2'd1; // Weakly not taken
  localparam counter_t CNT_MAX  = 2'd3;

  // One entry per index
  logic [`BTB_ENTRIES-1:0] valid_q;
  btb_tag_t                tag_q    [`BTB_ENTRIES];
  word_t                   target_q [`BTB_ENTRIES];
  counter_t                cnt_q    [`BTB_ENTRIES];

  btb_idx_t lk_idx;
  btb_tag_t lk_tag;
  logic     lk_hit;

  btb_idx_t up_idx;
  btb_tag_t up_tag;
  logic     up_hit;
  counter_t up_base;
  counter_t up_cnt;

  // Lookup side, purely combinational
  assign lk_idx = lookup_pc[`BTB_IDX_W+1:2];
  assign lk_tag = lookup_pc[`WORD_W-1:`BTB_IDX_W+2];
  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  assign predict_taken    = lk_hit && cnt_q[lk_idx][1];
  assign predicted_target = target_q[lk_idx]; // Only meaningful when taken

  // Update side
  assign up_idx = update_pc[`BTB_IDX_W+1:2];
  assign up_tag = update_pc[`WORD_W-1:`BTB_IDX_W+2];
  assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

  always_comb begin
    // A new or replaced entry trains from the weak not-taken state
    up_base = up_hit ? cnt_q[up_idx] : CNT_INIT;
    up_cnt  = up_base;
    if (branch_outcome) begin
      if (up_base != CNT_MAX) begin
        up_cnt = up_base + 2'd1;
      end
    end else if (up_base != CNT_MIN) begin
      up_cnt = up_base - 2'd1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        cnt_q[i] <= CNT_INIT;
      end
    end else if (update_btb) begin
      valid_q[up_idx] <= 1'b1;
      cnt_q[up_idx]   <= up_cnt;
    end
  end

  // Tag and target arrays
  always_ff @(posedge CLK) begin
    if (update_btb) begin
      tag_q[up_idx] <= up_tag;
      if (branch_outcome) begin
        target_q[up_idx] <= branch_target; // Not-taken keeps the old target
      end
    end
  end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_stage import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  // Instruction memory
  output logic  imemREN,
  output word_t imemaddr,
  input  logic  ihit,
  input  word_t imemload,
  // Scoreboard
  input  logic  freeze,
  input  logic  jump,
  output word_t pc,
  output word_t instr,
  output logic  predicted_outcome,
  // Branch resolution
  input  logic  misprediction,
  input  word_t correct_pc,
  input  logic  update_btb,
  input  word_t update_pc,
  input  logic  branch_outcome,
  input  word_t branch_target
);

  logic  redirect;
  logic  predict_taken;
  word_t predicted_target;

  logic  fetched;
  word_t fetched_pc;
  word_t fetched_instr;
  logic  fetched_pred;

  // Last word handed to the scoreboard, replayed under freeze
  word_t prev_pc;
  word_t prev_instr;
  logic  prev_pred;

  word_t save_pc; // Redirect target still awaited
  logic  missed;
  logic  on_target;
  logic  deliver;

  // Jumps come from decode, mispredictions with the resolving update
  assign redirect = jump || (update_btb && misprediction);

  assign on_target = !missed || (fetched_pc == save_pc);
  assign deliver   = fetched && !freeze && !redirect && on_target;

  always_comb begin
    pc                = '0; // Bubble by default
    instr             = '0;
    predicted_outcome = 1'b0;
    if (deliver) begin
      pc                = fetched_pc;
      instr             = fetched_instr;
      predicted_outcome = fetched_pred;
    end else if (freeze && !redirect && !missed) begin
      pc                = prev_pc;
      instr             = prev_instr;
      predicted_outcome = prev_pred;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prev_pc    <= '0;
      prev_instr <= '0;
      prev_pred  <= 1'b0;
    end else if (deliver) begin
      prev_pc    <= fetched_pc;
      prev_instr <= fetched_instr;
      prev_pred  <= fetched_pred;
    end
  end

  // Squash until the redirect target shows up
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      save_pc <= '0;
      missed  <= 1'b0;
    end else if (redirect) begin
      save_pc <= correct_pc;
      missed  <= 1'b1;
    end else if (deliver) begin
      missed  <= 1'b0;
    end
  end

  pc_unit pc_unit_i (
    .CLK              (CLK),
    .nRST             (nRST),
    .ihit             (ihit),
    .imemload         (imemload),
    .freeze           (freeze),
    .redirect         (redirect),
    .correct_pc       (correct_pc),
    .predict_taken    (predict_taken),
    .predicted_target (predicted_target),
    .imemREN          (imemREN),
    .imemaddr         (imemaddr),
    .fetched          (fetched),
    .fetched_pc       (fetched_pc),
    .fetched_instr    (fetched_instr),
    .fetched_pred     (fetched_pred)
  );

  // Looks up the address currently on the memory bus
  branch_predictor predictor_i (
    .CLK              (CLK),
    .nRST             (nRST),
    .lookup_pc        (imemaddr),
    .update_btb       (update_btb),
    .branch_outcome   (branch_outcome),
    .update_pc        (update_pc),
    .branch_target    (branch_target),
    .predict_taken    (predict_taken),
    .predicted_target (predicted_target)
  );

endmodule

/* verif/imem_model.sv */
`timescale 1ns/1ns

module imem_model import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  imemREN,
  input  word_t imemaddr,
  output logic  ihit,
  output word_t imemload
);

  integer seed = 32'h8ae484e4;

  logic  busy;     // A request is being timed
  logic  ready;    // Latency elapsed
  word_t req_addr;
  int    wait_cnt;

  // Answer only while the bus still shows the address being served
  assign ihit     = ready && imemREN && (imemaddr == req_addr);
  assign imemload = ihit ? (req_addr ^ 32'h2400_0001) : '0;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      ready    <= 1'b0;
      req_addr <= '0;
      wait_cnt <= 0;
    end else begin
      ready <= 1'b0;
      if (ready || !imemREN) begin
        busy <= 1'b0;
      end else if (!busy || imemaddr != req_addr) begin
        // New address, restart the latency count
        busy     <= 1'b1;
        req_addr <= imemaddr;
        wait_cnt <= $unsigned($random(seed)) % 3; // 0 to 2 extra cycles
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        ready <= 1'b1;
      end
    end
  end

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_tb import isa_pkg::*; ();

  localparam int WATCHDOG_CYCLES = 2000;
  localparam word_t BR_PC     = 32'h0000_2000; // Trained branch
  localparam word_t BR_TARGET = 32'h0000_3000;

  logic  CLK;
  logic  nRST;
  logic  imemREN;
  word_t imemaddr;
  logic  ihit;
  word_t imemload;
  logic  freeze;
  logic  jump;
  word_t pc;
  word_t instr;
  logic  predicted_outcome;
  logic  misprediction;
  word_t correct_pc;
  logic  update_btb;
  word_t update_pc;
  logic  branch_outcome;
  word_t branch_target;

  string test_name;

  fetch_stage dut_i (
    .CLK               (CLK),
    .nRST              (nRST),
    .imemREN           (imemREN),
    .imemaddr          (imemaddr),
    .ihit              (ihit),
    .imemload          (imemload),
    .freeze            (freeze),
    .jump              (jump),
    .pc                (pc),
    .instr             (instr),
    .predicted_outcome (predicted_outcome),
    .misprediction     (misprediction),
    .correct_pc        (correct_pc),
    .update_btb        (update_btb),
    .update_pc         (update_pc),
    .branch_outcome    (branch_outcome),
    .branch_target     (branch_target)
  );

  imem_model imem_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .imemREN  (imemREN),
    .imemaddr (imemaddr),
    .ihit     (ihit),
    .imemload (imemload)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Memory rule gives a word that is never zero
  function automatic word_t mem_word(word_t addr);
    return addr ^ 32'h2400_0001;
  endfunction

  task automatic fail_run(string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check(string what, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
      fail_run("output mismatch");
    end
  endtask

  // Next cycle with a non-zero instruction
  task automatic wait_word();
    int n;
    n = 0;
    @(negedge CLK);
    while (instr == '0 && n < 40) begin
      n++;
      @(negedge CLK);
    end
    if (instr == '0) fail_run("no instruction delivered within 40 cycles");
  endtask

  task automatic expect_word(word_t exp_pc, logic exp_pred);
    wait_word();
    check("pc", exp_pc, pc);
    check("instr", mem_word(exp_pc), instr);
    check("predicted_outcome", word_t'(exp_pred), word_t'(predicted_outcome));
  endtask

  // Straight-line run with nothing predicted taken
  task automatic expect_run(word_t first, int count);
    for (int i = 0; i < count; i++) begin
      expect_word(first + word_t'(4 * i), 1'b0);
    end
  endtask

  task automatic jump_to(word_t target);
    @(posedge CLK);
    jump       <= 1'b1;
    correct_pc <= target;
    @(posedge CLK);
    jump       <= 1'b0;
  endtask

  task automatic train_btb(word_t br_pc, logic taken, word_t target);
    @(posedge CLK);
    update_btb     <= 1'b1;
    update_pc      <= br_pc;
    branch_outcome <= taken;
    branch_target  <= target;
    @(posedge CLK);
    update_btb     <= 1'b0;
  endtask

  task automatic reset_behavior();
    test_name = "reset";
    for (int i = 0; i < 15; i++) begin
      @(negedge CLK);
      check("pc", '0, pc);
      check("instr", '0, instr);
      check("predicted_outcome", '0, word_t'(predicted_outcome));
    end
    @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK); // First cycle out of reset
    check("pc", '0, pc);
    check("instr", '0, instr);
    check("predicted_outcome", '0, word_t'(predicted_outcome));
    check("imemREN", 32'd1, word_t'(imemREN));
    check("imemaddr", `RESET_PC, imemaddr);
  endtask

  task automatic sequential_fetch();
    test_name = "sequential";
    expect_run(`RESET_PC, 8);
  endtask

  task automatic freeze_hold();
    word_t held_pc;
    word_t held_instr;
    logic  held_pred;
    test_name = "freeze";
    wait_word();
    held_pc    = pc;
    held_instr = instr;
    held_pred  = predicted_outcome;
    @(posedge CLK);
    freeze <= 1'b1;
    repeat (6) begin
      @(negedge CLK);
      check("held pc", held_pc, pc);
      check("held instr", held_instr, instr);
      check("held prediction", word_t'(held_pred), word_t'(predicted_outcome));
    end
    @(posedge CLK);
    freeze <= 1'b0;
    expect_word(held_pc + 32'd4, 1'b0); // Nothing skipped or repeated
  endtask

  task automatic jump_redirect();
    test_name = "jump";
    jump_to(32'h0000_0400);
    expect_run(32'h0000_0400, 3);
  endtask

  task automatic mispredict_redirect();
    test_name = "misprediction";
    @(posedge CLK);
    update_btb     <= 1'b1;
    misprediction  <= 1'b1;
    update_pc      <= 32'h0000_0a40;
    branch_outcome <= 1'b0; // Fell through
    correct_pc     <= 32'h0000_0a44;
    @(posedge CLK);
    update_btb    <= 1'b0;
    misprediction <= 1'b0;
    expect_run(32'h0000_0a44, 3);
  endtask

  task automatic btb_training();
    test_name = "btb taken";
    train_btb(BR_PC, 1'b1, BR_TARGET);
    train_btb(BR_PC, 1'b1, BR_TARGET);
    jump_to(BR_PC - 32'd8);
    expect_run(BR_PC - 32'd8, 2);
    expect_word(BR_PC, 1'b1);
    expect_run(BR_TARGET, 2);
    test_name = "btb not taken";
    train_btb(BR_PC, 1'b0, BR_TARGET);
    train_btb(BR_PC, 1'b0, BR_TARGET); // Back down to weakly not taken
    jump_to(BR_PC - 32'd4);
    expect_run(BR_PC - 32'd4, 3);
  endtask

  initial begin
    nRST           = 1'b0;
    freeze         = 1'b0;
    jump           = 1'b0;
    misprediction  = 1'b0;
    correct_pc     = '0;
    update_btb     = 1'b0;
    update_pc      = '0;
    branch_outcome = 1'b0;
    branch_target  = '0;
    reset_behavior();
    sequential_fetch();
    freeze_hold();
    jump_redirect();
    mispredict_redirect();
    btb_training();
    $display("** PASS **");
    $finish;
  end

  // Sum of worst-case test lengths with plenty of margin
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

/* all.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/pc_unit.sv
verilog/branch_predictor.sv
verilog/fetch_stage.sv
verif/imem_model.sv
verif/fetch_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run the fetch testbench
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ns --top-module fetch_tb \
    -f all.f -o fetch_sim &&
  ./obj_dir/fetch_sim ||
  exit 1
